/* hw/usb_ep_pkg.sv */
/*
 * Shared definitions of the endpoint status store
 *  - address, status word and endpoint id types
 *  - entry count, status word layout and read latency
 *  - transaction outcome and update FSM enums
 */

`default_nettype none

package usb_ep_pkg;

	// RAM and register address
	typedef logic [7:0] ep_addr_t;

	// One status word per entry
	typedef logic [15:0] ep_word_t;

	// Endpoint number and direction, zero-extended into the RAM address
	typedef logic [4:0] ep_id_t;

	// Entries at or above this index are unmapped
	localparam int NUM_EP_ENTRIES = 24;

	// Status word layout
	localparam int TOGGLE_BIT = 0;
	localparam int HALT_BIT   = 1;
	localparam int COUNT_LSB  = 8;
	localparam int COUNT_W    = 8;

	// Read presented to data in the output register
	localparam int RD_LATENCY = 3;

	// Counter used while a read is in flight
	typedef logic [$clog2(RD_LATENCY)-1:0] lat_cnt_t;

	// Outcome of a finished endpoint transaction
	typedef enum logic [1:0] {
		OUT_ACK   = 2'd0,
		OUT_NAK   = 2'd1,
		OUT_STALL = 2'd2
	} txn_outcome_e;

	// Update stage FSM
	typedef enum logic [2:0] {
		IDLE,
		READ,
		WAIT,
		WRITE,
		RESP
	} upd_state_e;

endpackage

`default_nettype wire

/* hw/usb_ep_status.sv */
/*
 * Endpoint status RAM, three-stage pipeline
 *  - priority port, always served
 *  - auxiliary port, taken only while the priority port is quiet
 *  - zero read on either port returns 0 instead of the stored word
 */

`default_nettype none

module usb_ep_status
	import usb_ep_pkg::*;
(
	input  wire           clk,
	input  wire           rst_n,

	// Priority port
	input  wire ep_addr_t p_addr,
	input  wire           p_read,
	input  wire           p_zero,
	input  wire           p_write,
	input  wire ep_word_t p_din,
	output ep_word_t      p_dout,

	// Auxiliary port
	input  wire ep_addr_t s_addr,
	input  wire           s_read,
	input  wire           s_zero,
	input  wire           s_write,
	input  wire ep_word_t s_din,
	output ep_word_t      s_dout,
	output logic          s_ready
);

	// Stage 1 signals
	logic     p_act;
	ep_addr_t addr_1;
	ep_word_t din_1;
	logic     we_1;
	logic     p_read_1;
	logic     p_zero_1;
	logic     s_read_1;
	logic     s_zero_1;

	// Stage 2 signals
	ep_word_t ram [0:(1 << $bits(ep_addr_t)) - 1];
	ep_word_t ram_rd;
	logic     p_read_2;
	logic     p_zero_2;
	logic     s_read_2;
	logic     s_zero_2;

	// Priority side owns the RAM whenever it issues anything
	assign p_act   = p_read | p_write;
	assign s_ready = ~p_act;

	// Stage 1: address and write data mux
	always_ff @(posedge clk)
	begin
		addr_1 <= p_act ? p_addr : s_addr;
		din_1  <= p_write ? p_din : s_din;
	end

	// Stage 1: command strobes, aux only when granted
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			we_1     <= 1'b0;
			p_read_1 <= 1'b0;
			p_zero_1 <= 1'b0;
			s_read_1 <= 1'b0;
			s_zero_1 <= 1'b0;
		end
		else
		begin
			we_1     <= p_write | (s_write & s_ready);
			p_read_1 <= p_read;
			p_zero_1 <= p_zero;
			s_read_1 <= s_read & s_ready;
			s_zero_1 <= s_zero & s_ready;
		end
	end

	// Stage 2: synchronous RAM, read returns the old word on a collision
	always_ff @(posedge clk)
	begin
		ram_rd <= ram[addr_1];
		if (we_1)
			ram[addr_1] <= din_1;
	end

	// Stage 2: read tracking
	// Zero reads ride the same slot as normal reads
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			p_read_2 <= 1'b0;
			p_zero_2 <= 1'b0;
			s_read_2 <= 1'b0;
			s_zero_2 <= 1'b0;
		end
		else
		begin
			p_read_2 <= p_read_1 | p_zero_1;
			p_zero_2 <= p_zero_1;
			s_read_2 <= s_read_1 | s_zero_1;
			s_zero_2 <= s_zero_1;
		end
	end

	// Stage 3: output registers
	// Hold until the next read on the same port
	always_ff @(posedge clk)
	begin
		if (p_read_2)
			p_dout <= p_zero_2 ? '0 : ram_rd;
		if (s_read_2)
			s_dout <= s_zero_2 ? '0 : ram_rd;
	end

	// One priority command per cycle from the update stage
	a_p_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(p_read && p_write));

endmodule

`default_nettype wire

/* hw/usb_ep_txn_update.sv */
/*
 * Transaction outcome update stage
 *  - accepts one outcome event at a time
 *  - read-modify-write of the endpoint status word on the priority port
 *  - returns the old word on the response channel
 */

`default_nettype none

module usb_ep_txn_update
	import usb_ep_pkg::*;
(
	input  wire               clk,
	input  wire               rst_n,

	// Event channel
	input  wire               evt_valid,
	output logic              evt_ready,
	input  wire ep_id_t       evt_ep,
	input  wire txn_outcome_e evt_outcome,

	// Update response channel
	output logic              upd_valid,
	input  wire               upd_ready,
	output ep_id_t            upd_ep,
	output ep_word_t          upd_old,

	// Priority port of the status RAM
	output ep_addr_t          p_addr,
	output logic              p_read,
	output logic              p_zero,
	output logic              p_write,
	output ep_word_t          p_din,
	input  wire ep_word_t     p_dout
);

	// Control
	upd_state_e   state_q;
	lat_cnt_t     cnt_q;
	logic         wr_q;
	logic         unmapped;

	// Payload
	ep_id_t       ep_q;
	txn_outcome_e outcome_q;
	ep_word_t     old_q;
	ep_word_t     new_q;
	ep_word_t     new_word;

	// Endpoints past the table get a zero read and no write-back
	assign unmapped = ep_addr_t'(ep_q) >= ep_addr_t'(NUM_EP_ENTRIES);

	// Apply the outcome to the old word
	always_comb
	begin
		new_word = old_q;
		case (outcome_q)
			OUT_ACK:
			begin
				new_word[TOGGLE_BIT] = ~old_q[TOGGLE_BIT];
				// Count wraps at 255
				new_word[COUNT_LSB +: COUNT_W] = old_q[COUNT_LSB +: COUNT_W] + COUNT_W'(1);
			end
			OUT_STALL:
				new_word[HALT_BIT] = 1'b1;
			// NAK writes back unchanged
			default:
				new_word = old_q;
		endcase
	end

	// FSM
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state_q <= IDLE;
			cnt_q   <= '0;
			wr_q    <= 1'b0;
		end
		else
		begin
			// Write strobe lasts one cycle
			wr_q <= 1'b0;
			case (state_q)
				IDLE:
					if (evt_valid)
						state_q <= READ;
				READ:
				begin
					state_q <= WAIT;
					cnt_q   <= lat_cnt_t'(RD_LATENCY - 1);
				end
				WAIT:
					if (cnt_q == '0)
						state_q <= WRITE;
					else
						cnt_q <= cnt_q - lat_cnt_t'(1);
				WRITE:
				begin
					state_q <= RESP;
					wr_q    <= ~unmapped;
				end
				RESP:
					if (upd_ready)
						state_q <= IDLE;
				default:
					state_q <= IDLE;
			endcase
		end
	end

	// Event latch, old word capture, new word register
	always_ff @(posedge clk)
	begin
		if ((state_q == IDLE) && evt_valid)
		begin
			ep_q      <= evt_ep;
			outcome_q <= evt_outcome;
		end
		// Word is in p_dout on the last wait cycle
		if ((state_q == WAIT) && (cnt_q == '0))
			old_q <= p_dout;
		if (state_q == WRITE)
			new_q <= new_word;
	end

	// Handshakes
	assign evt_ready = (state_q == IDLE);
	assign upd_valid = (state_q == RESP);
	assign upd_ep    = ep_q;
	assign upd_old   = old_q;

	// Priority port
	assign p_addr  = ep_addr_t'(ep_q);
	assign p_read  = (state_q == READ);
	assign p_zero  = (state_q == READ) && unmapped;
	assign p_write = wr_q;
	assign p_din   = new_q;

	// Source holds the event payload while it waits
	a_evt_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(evt_valid && !evt_ready) ##1 evt_valid |-> $stable(evt_ep) && $stable(evt_outcome));

endmodule

`default_nettype wire

/* hw/usb_ep_csr_bridge.sv */
/*
 * Host register bridge
 *  - one outstanding request, presented on the auxiliary port until taken
 *  - unmapped reads become zero reads, unmapped writes are dropped
 */

`default_nettype none

module usb_ep_csr_bridge
	import usb_ep_pkg::*;
(
	input  wire           clk,
	input  wire           rst_n,

	// Host request channel
	input  wire           req_valid,
	output logic          req_ready,
	input  wire ep_addr_t req_addr,
	input  wire           req_write,
	input  wire ep_word_t req_wdata,

	// Host response channel
	output logic          rsp_valid,
	input  wire           rsp_ready,
	output ep_word_t      rsp_rdata,

	// Auxiliary port of the status RAM
	output ep_addr_t      s_addr,
	output logic          s_read,
	output logic          s_zero,
	output logic          s_write,
	output ep_word_t      s_din,
	input  wire ep_word_t s_dout,
	input  wire           s_ready
);

	// Control
	logic     pend_q;
	logic     wait_q;
	logic     rsp_q;
	lat_cnt_t cnt_q;
	logic     taken;
	logic     unmapped;

	// Request and response payload
	ep_addr_t addr_q;
	logic     write_q;
	ep_word_t wdata_q;
	ep_word_t rdata_q;

	assign unmapped  = addr_q >= ep_addr_t'(NUM_EP_ENTRIES);
	assign taken     = pend_q && s_ready;
	assign req_ready = ~(pend_q | wait_q | rsp_q);

	// Command stays up until the RAM grants it
	assign s_addr  = addr_q;
	assign s_din   = wdata_q;
	assign s_read  = pend_q && !write_q;
	assign s_zero  = pend_q && !write_q && unmapped;
	assign s_write = pend_q && write_q && !unmapped;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pend_q <= 1'b0;
			wait_q <= 1'b0;
			rsp_q  <= 1'b0;
			cnt_q  <= '0;
		end
		else
		begin
			if (req_valid && req_ready)
				pend_q <= 1'b1;
			// Writes answer right away, reads wait for the pipeline
			if (taken)
			begin
				pend_q <= 1'b0;
				if (write_q)
					rsp_q <= 1'b1;
				else
				begin
					wait_q <= 1'b1;
					cnt_q  <= lat_cnt_t'(RD_LATENCY - 1);
				end
			end
			if (wait_q)
			begin
				if (cnt_q == '0)
				begin
					wait_q <= 1'b0;
					rsp_q  <= 1'b1;
				end
				else
					cnt_q <= cnt_q - lat_cnt_t'(1);
			end
			if (rsp_q && rsp_ready)
				rsp_q <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (req_valid && req_ready)
		begin
			addr_q  <= req_addr;
			write_q <= req_write;
			wdata_q <= req_wdata;
		end
		if (taken && write_q)
			rdata_q <= '0;
		// s_dout is loaded by now
		if (wait_q && (cnt_q == '0))
			rdata_q <= s_dout;
	end

	assign rsp_valid = rsp_q;
	assign rsp_rdata = rdata_q;

	// Response held until the host takes it
	a_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata));

endmodule

`default_nettype wire

/* hw/usb_ep_status_top.sv */
/*
 * Endpoint status store top level
 *  - transaction update stage on the priority port
 *  - host register bridge on the auxiliary port
 *  - shared status RAM
 */

`default_nettype none

module usb_ep_status_top
	import usb_ep_pkg::*;
(
	input  wire               clk,
	input  wire               rst_n,

	// Event channel
	input  wire               evt_valid,
	output logic              evt_ready,
	input  wire ep_id_t       evt_ep,
	input  wire txn_outcome_e evt_outcome,

	// Update response channel
	output logic              upd_valid,
	input  wire               upd_ready,
	output ep_id_t            upd_ep,
	output ep_word_t          upd_old,

	// Host request channel
	input  wire               req_valid,
	output logic              req_ready,
	input  wire ep_addr_t     req_addr,
	input  wire               req_write,
	input  wire ep_word_t     req_wdata,

	// Host response channel
	output logic              rsp_valid,
	input  wire               rsp_ready,
	output ep_word_t          rsp_rdata
);

	// Priority port
	ep_addr_t p_addr;
	logic     p_read;
	logic     p_zero;
	logic     p_write;
	ep_word_t p_din;
	ep_word_t p_dout;

	// Auxiliary port
	ep_addr_t s_addr;
	logic     s_read;
	logic     s_zero;
	logic     s_write;
	ep_word_t s_din;
	ep_word_t s_dout;
	logic     s_ready;

	usb_ep_txn_update u_txn_update (
		.clk         (clk),
		.rst_n       (rst_n),
		.evt_valid   (evt_valid),
		.evt_ready   (evt_ready),
		.evt_ep      (evt_ep),
		.evt_outcome (evt_outcome),
		.upd_valid   (upd_valid),
		.upd_ready   (upd_ready),
		.upd_ep      (upd_ep),
		.upd_old     (upd_old),
		.p_addr      (p_addr),
		.p_read      (p_read),
		.p_zero      (p_zero),
		.p_write     (p_write),
		.p_din       (p_din),
		.p_dout      (p_dout)
	);

	usb_ep_csr_bridge u_csr_bridge (
		.clk       (clk),
		.rst_n     (rst_n),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.req_addr  (req_addr),
		.req_write (req_write),
		.req_wdata (req_wdata),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready),
		.rsp_rdata (rsp_rdata),
		.s_addr    (s_addr),
		.s_read    (s_read),
		.s_zero    (s_zero),
		.s_write   (s_write),
		.s_din     (s_din),
		.s_dout    (s_dout),
		.s_ready   (s_ready)
	);

	usb_ep_status u_status (
		.clk     (clk),
		.rst_n   (rst_n),
		.p_addr  (p_addr),
		.p_read  (p_read),
		.p_zero  (p_zero),
		.p_write (p_write),
		.p_din   (p_din),
		.p_dout  (p_dout),
		.s_addr  (s_addr),
		.s_read  (s_read),
		.s_zero  (s_zero),
		.s_write (s_write),
		.s_din   (s_din),
		.s_dout  (s_dout),
		.s_ready (s_ready)
	);

endmodule

`default_nettype wire

/* dv/usb_ep_status_tb.sv */
/*
 * Testbench of the endpoint status store
 *  - stimulus table of host writes, host reads and outcome events
 *  - reference model of the status words
 *  - random ready back-pressure, value check and watchdog
 */

`default_nettype none

module usb_ep_status_tb
	import usb_ep_pkg::*;
();

	// Row kinds
	localparam int ROW_WRITE      = 0;
	localparam int ROW_READ       = 1;
	localparam int ROW_EVENT      = 2;
	localparam int MAX_ROWS       = 192;
	localparam int CYCLES_PER_ROW = 40;

	// DUT signals
	logic         clk;
	logic         rst_n;
	logic         evt_valid;
	logic         evt_ready;
	ep_id_t       evt_ep;
	txn_outcome_e evt_outcome;
	logic         upd_valid;
	logic         upd_ready;
	ep_id_t       upd_ep;
	ep_word_t     upd_old;
	logic         req_valid;
	logic         req_ready;
	ep_addr_t     req_addr;
	logic         req_write;
	ep_word_t     req_wdata;
	logic         rsp_valid;
	logic         rsp_ready;
	ep_word_t     rsp_rdata;

	// One stimulus table row per operation
	int       row_kind [0:MAX_ROWS-1];
	ep_addr_t row_addr [0:MAX_ROWS-1];
	// Write data or the outcome in the low bits
	ep_word_t row_data [0:MAX_ROWS-1];
	// Row starts together with the next one
	bit       row_with_next [0:MAX_ROWS-1];
	int       row_cnt;
	bit       built;

	// Expected contents of the status RAM
	ep_word_t model_mem [0:255];

	integer   seed;
	int       idx;

	usb_ep_status_top DUT (
		.clk         (clk),
		.rst_n       (rst_n),
		.evt_valid   (evt_valid),
		.evt_ready   (evt_ready),
		.evt_ep      (evt_ep),
		.evt_outcome (evt_outcome),
		.upd_valid   (upd_valid),
		.upd_ready   (upd_ready),
		.upd_ep      (upd_ep),
		.upd_old     (upd_old),
		.req_valid   (req_valid),
		.req_ready   (req_ready),
		.req_addr    (req_addr),
		.req_write   (req_write),
		.req_wdata   (req_wdata),
		.rsp_valid   (rsp_valid),
		.rsp_ready   (rsp_ready),
		.rsp_rdata   (rsp_rdata)
	);

	always #5 clk = ~clk;

	function automatic int rand_below(input int n);
		int r;
		r = $random(seed) & 32'h7fffffff;
		return r % n;
	endfunction

	function automatic bit is_mapped(input ep_addr_t a);
		return int'(a) < NUM_EP_ENTRIES;
	endfunction

	// Status word after one transaction outcome
	function automatic ep_word_t next_status(input ep_word_t w, input txn_outcome_e o);
		ep_word_t n;
		logic [COUNT_W-1:0] cnt;
		n   = w;
		cnt = w[COUNT_LSB +: COUNT_W];
		if (o == OUT_ACK)
		begin
			n[TOGGLE_BIT] = ~w[TOGGLE_BIT];
			// 255 rolls over to 0
			n[COUNT_LSB +: COUNT_W] = (cnt == {COUNT_W{1'b1}}) ? '0 : cnt + 1'b1;
		end
		else if (o == OUT_STALL)
			n[HALT_BIT] = 1'b1;
		return n;
	endfunction

	function automatic void add_row(input int kind, input ep_addr_t a, input ep_word_t d,
		input bit with_next);
		row_kind[row_cnt]      = kind;
		row_addr[row_cnt]      = a;
		row_data[row_cnt]      = d;
		row_with_next[row_cnt] = with_next;
		row_cnt                = row_cnt + 1;
	endfunction

	function automatic void build_table();
		int i;
		int e;
		int h;
		row_cnt = 0;
		// Fill every mapped entry, then read all back
		for (i = 0; i < NUM_EP_ENTRIES; i++)
			add_row(ROW_WRITE, ep_addr_t'(i), ep_word_t'($random(seed)), 1'b0);
		for (i = 0; i < NUM_EP_ENTRIES; i++)
			add_row(ROW_READ, ep_addr_t'(i), '0, 1'b0);
		// Two ACKs take the count from 254 through 255 to 0
		add_row(ROW_WRITE, 8'd5, 16'hfe02, 1'b0);
		add_row(ROW_EVENT, 8'd5, ep_word_t'(OUT_ACK), 1'b0);
		add_row(ROW_READ, 8'd5, '0, 1'b0);
		add_row(ROW_EVENT, 8'd5, ep_word_t'(OUT_ACK), 1'b0);
		add_row(ROW_READ, 8'd5, '0, 1'b0);
		// STALL on a word with halt clear, then NAK
		add_row(ROW_WRITE, 8'd9, 16'h4c01, 1'b0);
		add_row(ROW_EVENT, 8'd9, ep_word_t'(OUT_STALL), 1'b0);
		add_row(ROW_READ, 8'd9, '0, 1'b0);
		add_row(ROW_EVENT, 8'd10, ep_word_t'(OUT_NAK), 1'b0);
		add_row(ROW_READ, 8'd10, '0, 1'b0);
		// Unmapped endpoints and addresses
		add_row(ROW_EVENT, 8'd24, ep_word_t'(OUT_ACK), 1'b0);
		add_row(ROW_EVENT, 8'd31, ep_word_t'(OUT_STALL), 1'b0);
		add_row(ROW_READ, 8'd24, '0, 1'b0);
		add_row(ROW_READ, 8'd200, '0, 1'b0);
		add_row(ROW_WRITE, 8'd30, 16'hbeef, 1'b0);
		add_row(ROW_READ, 8'd30, '0, 1'b0);
		add_row(ROW_WRITE, 8'd255, 16'h1234, 1'b0);
		add_row(ROW_READ, 8'd255, '0, 1'b0);
		// Host op paired with an event on another entry
		for (i = 0; i < 20; i++)
		begin
			e = rand_below(28);
			h = (e + 1 + rand_below(NUM_EP_ENTRIES - 1)) % NUM_EP_ENTRIES;
			if (rand_below(2) == 0)
				add_row(ROW_WRITE, ep_addr_t'(h), ep_word_t'($random(seed)), 1'b1);
			else
				add_row(ROW_READ, ep_addr_t'(h), '0, 1'b1);
			add_row(ROW_EVENT, ep_addr_t'(e), ep_word_t'(rand_below(3)), 1'b0);
		end
		// Final sweep against the model
		for (i = 0; i < NUM_EP_ENTRIES; i++)
			add_row(ROW_READ, ep_addr_t'(i), '0, 1'b0);
		built = 1'b1;
	endfunction

	task automatic check_value(input string name, input ep_word_t got, input ep_word_t exp);
		if (got !== exp)
		begin
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			$display("STATUS: FAIL");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	// One host request and its response
	task automatic host_op(input ep_addr_t a, input logic wr, input ep_word_t d,
		input ep_word_t exp);
		bit done;
		done = 1'b0;
		@(negedge clk);
		req_valid = 1'b1;
		req_addr  = a;
		req_write = wr;
		req_wdata = d;
		// Ready seen here means transfer at the next rising edge
		while (!req_ready)
			@(negedge clk);
		@(negedge clk);
		req_valid = 1'b0;
		while (!done)
		begin
			rsp_ready = (rand_below(4) != 0);
			if (rsp_valid && rsp_ready)
			begin
				check_value("rsp_rdata", rsp_rdata, exp);
				done = 1'b1;
			end
			@(negedge clk);
		end
		rsp_ready = 1'b0;
	endtask

	// One outcome event and its update response
	task automatic event_op(input ep_id_t ep, input txn_outcome_e o, input ep_word_t exp);
		bit done;
		done = 1'b0;
		@(negedge clk);
		evt_valid   = 1'b1;
		evt_ep      = ep;
		evt_outcome = o;
		while (!evt_ready)
			@(negedge clk);
		@(negedge clk);
		evt_valid = 1'b0;
		while (!done)
		begin
			upd_ready = (rand_below(4) != 0);
			if (upd_valid && upd_ready)
			begin
				check_value("upd_ep", 16'(upd_ep), 16'(ep));
				check_value("upd_old", upd_old, exp);
				done = 1'b1;
			end
			@(negedge clk);
		end
		upd_ready = 1'b0;
	endtask

	// Model follows each row as it starts
	// Paired rows never share an entry
	task automatic apply_row(input int r);
		ep_addr_t     a;
		ep_word_t     exp;
		txn_outcome_e o;
		a   = row_addr[r];
		exp = is_mapped(a) ? model_mem[a] : '0;
		o   = txn_outcome_e'(row_data[r][1:0]);
		case (row_kind[r])
			ROW_WRITE:
			begin
				if (is_mapped(a))
					model_mem[a] = row_data[r];
				host_op(a, 1'b1, row_data[r], '0);
			end
			ROW_READ:
				host_op(a, 1'b0, '0, exp);
			default:
			begin
				if (is_mapped(a))
					model_mem[a] = next_status(exp, o);
				event_op(a[4:0], o, exp);
			end
		endcase
	endtask

	// Watchdog
	initial
	begin
		wait (built);
		repeat (row_cnt * CYCLES_PER_ROW) @(posedge clk);
		$display("timeout: %0d rows did not finish within %0d cycles",
			row_cnt, row_cnt * CYCLES_PER_ROW);
		$display("STATUS: FAIL");
		$fatal(1, "watchdog expired");
	end

	initial
	begin
		clk         = 1'b0;
		rst_n       = 1'b0;
		evt_valid   = 1'b0;
		evt_ep      = '0;
		evt_outcome = OUT_NAK;
		upd_ready   = 1'b0;
		req_valid   = 1'b0;
		req_addr    = '0;
		req_write   = 1'b0;
		req_wdata   = '0;
		rsp_ready   = 1'b0;
		seed        = 28656;
		built       = 1'b0;
		build_table();
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		// Handshake state out of reset
		check_value("evt_ready", 16'(evt_ready), 16'h1);
		check_value("req_ready", 16'(req_ready), 16'h1);
		check_value("upd_valid", 16'(upd_valid), 16'h0);
		check_value("rsp_valid", 16'(rsp_valid), 16'h0);
		idx = 0;
		while (idx < row_cnt)
		begin
			if (row_with_next[idx] && (idx + 1 < row_cnt))
			begin
				fork
					apply_row(idx);
					apply_row(idx + 1);
				join
				idx = idx + 2;
			end
			else
			begin
				apply_row(idx);
				idx = idx + 1;
			end
		end
		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
hw/usb_ep_pkg.sv
hw/usb_ep_status.sv
hw/usb_ep_txn_update.sv
hw/usb_ep_csr_bridge.sv
hw/usb_ep_status_top.sv
dv/usb_ep_status_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the endpoint status store testbench with Verilator
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log
TOP=usb_ep_status_tb

rm -f "$LOG_FILE"

verilator --binary --timing --assert -j 0 \
	--top-module "$TOP" \
	--Mdir "$BUILD_DIR" \
	-f compile.f

# The log decides the result
"./$BUILD_DIR/V$TOP" 2>&1 | tee "$LOG_FILE"

if grep -q "^STATUS: PASS$" "$LOG_FILE"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see $LOG_FILE"
	exit 1
fi
